// ==== design/memif_pkg.sv ====
package memif_pkg;

    //////////////////////////////////////////////////////////////////////
    // Burst geometry of the controller user port
    //////////////////////////////////////////////////////////////////////

    // 128-bit data bus
    localparam int unsigned word_bytes  = 16;
    localparam int unsigned word_bits   = 8 * word_bytes;
    // Words moved by one command
    localparam int unsigned burst_len   = 16;
    localparam int unsigned burst_bytes = word_bytes * burst_len;
    // Controller takes a byte address
    localparam int unsigned addr_bits   = 30;
    // Room for one burst being issued plus the next one filling
    localparam int unsigned count_bits  = 7;

    // Command instruction codes
    localparam logic [2:0] cmd_write = 3'd0;
    localparam logic [2:0] cmd_read  = 3'd1;

    //////////////////////////////////////////////////////////////////////
    // FSM encodings
    //////////////////////////////////////////////////////////////////////

    // Write sequencer
    localparam logic [1:0] wr_idle  = 2'd0;
    localparam logic [1:0] wr_push  = 2'd1;
    localparam logic [1:0] wr_issue = 2'd2;

    // Read sequencer
    localparam logic [1:0] rd_idle       = 2'd0;
    localparam logic [1:0] rd_wait_fill  = 2'd1;
    localparam logic [1:0] rd_wait_drain = 2'd2;
    localparam logic [1:0] rd_issue      = 2'd3;

    // Command issuer
    localparam logic iss_wait = 1'b0;
    localparam logic iss_act  = 1'b1;

    typedef logic [addr_bits-1:0] byte_addr_t;
    typedef logic [word_bits-1:0] pix_word_t;

endpackage

// ==== design/wr_burst_seq.sv ====
`timescale 1ns/1ps

module wr_burst_seq
    import memif_pkg::*;
#(
    parameter int unsigned frame_bytes = 3840000
) (
    input  logic       clk_mif,
    input  logic       rst,
    input  logic       calib_done,
    input  logic       vsync,
    input  logic       push,
    input  logic       issue_done,
    output logic       issue_req,
    output byte_addr_t wr_addr
);

    logic [1:0]            state;
    logic [count_bits-1:0] word_count;
    logic [count_bits-1:0] count_next;
    logic                  last_burst;

    // Words pushed into the write FIFO, counted in every active state
    assign count_next = word_count + {{(count_bits - 1){1'b0}}, push};

    // Last burst of the frame is being issued
    assign last_burst = (wr_addr == byte_addr_t'(frame_bytes - burst_bytes));

    //////////////////////////////////////////////////////////////////////
    // Push / issue FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_mif) begin
        if (rst) begin
            state      <= wr_idle;
            word_count <= '0;
            wr_addr    <= '0;
        end else begin
            case (state)
                wr_idle: begin
                    // Frame starts only once memory is calibrated
                    if (calib_done && vsync) begin
                        word_count <= '0;
                        wr_addr    <= '0;
                        state      <= wr_push;
                    end
                end
                wr_push: begin
                    word_count <= count_next;
                    // A full burst is sitting in the write FIFO
                    if (count_next >= count_bits'(burst_len)) begin
                        state <= wr_issue;
                    end
                end
                wr_issue: begin
                    if (issue_done) begin
                        // Burst handed to the controller, keep the overflow words
                        word_count <= count_next - count_bits'(burst_len);
                        if (last_burst) begin
                            wr_addr <= '0;
                            state   <= wr_idle;
                        end else begin
                            wr_addr <= wr_addr + byte_addr_t'(burst_bytes);
                            state   <= wr_push;
                        end
                    end else begin
                        // Next burst keeps filling while this one waits
                        word_count <= count_next;
                    end
                end
                default: begin
                    state <= wr_idle;
                end
            endcase
        end
    end

    // Request held until the issuer answers
    assign issue_req = (state == wr_issue);

    // Write address wraps to zero at frame end and never points past it
    wr_addr_in_frame: assert property (
        @(posedge clk_mif) disable iff (rst)
        wr_addr < byte_addr_t'(frame_bytes)
    );

endmodule

// ==== design/rd_burst_seq.sv ====
`timescale 1ns/1ps

module rd_burst_seq
    import memif_pkg::*;
#(
    parameter int unsigned frame_bytes = 3840000
) (
    input  logic       clk_mif,
    input  logic       rst,
    input  logic       calib_done,
    input  logic       vsync,
    input  logic       rd_empty,
    input  logic       pix_read_ready,
    input  logic       issue_done,
    output logic       issue_req,
    output byte_addr_t rd_addr
);

    logic [1:0] state;
    logic       last_burst;

    assign last_burst = (rd_addr == byte_addr_t'(frame_bytes - burst_bytes));

    //////////////////////////////////////////////////////////////////////
    // One read burst in flight at a time
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_mif) begin
        if (rst) begin
            state   <= rd_idle;
            rd_addr <= '0;
        end else begin
            case (state)
                rd_idle: begin
                    if (calib_done && vsync) begin
                        rd_addr <= '0;
                        state   <= rd_wait_drain;
                    end
                end
                rd_wait_fill: begin
                    // Data of the last burst has started to land
                    if (!rd_empty) begin
                        state <= rd_wait_drain;
                    end
                end
                rd_wait_drain: begin
                    // FIFO empty and the pixel side able to take more
                    if (pix_read_ready && rd_empty) begin
                        state <= rd_issue;
                    end
                end
                rd_issue: begin
                    if (issue_done) begin
                        // Address moves on after the last burst too,
                        // so frame_bytes marks a fully read frame for the
                        // write gate in the issuer
                        rd_addr <= rd_addr + byte_addr_t'(burst_bytes);
                        if (last_burst) begin
                            state <= rd_idle;
                        end else begin
                            state <= rd_wait_fill;
                        end
                    end
                end
                default: begin
                    state <= rd_idle;
                end
            endcase
        end
    end

    assign issue_req = (state == rd_issue);

    // Only an idle sequencer may hold the end-of-frame address
    rd_addr_in_frame: assert property (
        @(posedge clk_mif) disable iff (rst)
        (state != rd_idle) |-> (rd_addr < byte_addr_t'(frame_bytes))
    );

endmodule

// ==== design/cmd_issuer.sv ====
`timescale 1ns/1ps

module cmd_issuer
    import memif_pkg::*;
(
    input  logic       clk_mif,
    input  logic       rst,
    input  logic       cmd_full,
    input  logic       rd_req,
    input  byte_addr_t rd_addr,
    input  logic       wr_req,
    input  byte_addr_t wr_addr,
    output logic       rd_done,
    output logic       wr_done,
    output logic       cmd_en,
    output logic [2:0] cmd_instr,
    output byte_addr_t cmd_addr
);

    logic state;
    logic rd_pick;
    logic wr_pick;
    logic issue;

    // Reads always win
    assign rd_pick = !cmd_full && rd_req;
    // Writes only behind data that has already been read out
    assign wr_pick = !cmd_full && !rd_req && wr_req && (wr_addr < rd_addr);
    assign issue   = (state == iss_wait) && (rd_pick || wr_pick);

    //////////////////////////////////////////////////////////////////////
    // Issue FSM, one command every two cycles at most
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_mif) begin
        if (rst) begin
            state   <= iss_wait;
            cmd_en  <= 1'b0;
            rd_done <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            case (state)
                iss_wait: begin
                    cmd_en  <= issue;
                    rd_done <= issue && rd_pick;
                    wr_done <= issue && wr_pick;
                    if (issue) begin
                        state <= iss_act;
                    end
                end
                default: begin
                    // Strobe and done pulse last a single cycle
                    cmd_en  <= 1'b0;
                    rd_done <= 1'b0;
                    wr_done <= 1'b0;
                    state   <= iss_wait;
                end
            endcase
        end
    end

    // Command fields, loaded with the strobe
    always_ff @(posedge clk_mif) begin
        if (issue) begin
            cmd_instr <= rd_pick ? cmd_read : cmd_write;
            cmd_addr  <= rd_pick ? rd_addr : wr_addr;
        end
    end

    // Dead cycle after every command
    cmd_en_spaced: assert property (
        @(posedge clk_mif) disable iff (rst)
        cmd_en |=> !cmd_en
    );

    // Write never overtakes the read pointer seen at issue time
    wr_behind_rd: assert property (
        @(posedge clk_mif) disable iff (rst)
        (cmd_en && (cmd_instr == cmd_write)) |-> (cmd_addr < $past(rd_addr))
    );

endmodule

// ==== design/memif.sv ====
`timescale 1ns/1ps

module memif
    import memif_pkg::*;
#(
    parameter int unsigned frame_bytes = 3840000
) (
    input  logic       clk_mif,
    input  logic       rst,
    input  logic       calib_done,
    input  logic       vsync,
    // Pixel input
    input  pix_word_t  pix_write,
    input  logic       pix_write_valid,
    output logic       pix_write_ready,
    // Pixel output
    output pix_word_t  pix_read,
    output logic       pix_read_valid,
    input  logic       pix_read_ready,
    // Controller command port
    output logic       cmd_en,
    output logic [2:0] cmd_instr,
    output byte_addr_t cmd_addr,
    input  logic       cmd_full,
    // Controller write FIFO
    output logic       wr_en,
    output pix_word_t  wr_data,
    input  logic       wr_full,
    // Controller read FIFO, first word fall through
    output logic       rd_en,
    input  pix_word_t  rd_data,
    input  logic       rd_empty
);

    logic       pix_write_fire;
    logic       wr_req;
    logic       wr_done;
    byte_addr_t wr_addr;
    logic       rd_req;
    logic       rd_done;
    byte_addr_t rd_addr;

    //////////////////////////////////////////////////////////////////////
    // Pixel handshakes
    //////////////////////////////////////////////////////////////////////

    assign pix_write_ready = !wr_full;
    assign pix_write_fire  = pix_write_valid && !wr_full;

    assign pix_read_valid = !rd_empty;
    assign pix_read       = rd_data;
    assign rd_en          = !rd_empty && pix_read_ready;

    // Accepted pixel lands in the write FIFO one cycle later
    always_ff @(posedge clk_mif) begin
        if (rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= pix_write_fire;
        end
    end

    always_ff @(posedge clk_mif) begin
        wr_data <= pix_write;
    end

    wr_burst_seq #(.frame_bytes(frame_bytes)) wr_seq_inst (
        .clk_mif(clk_mif), .rst(rst), .calib_done(calib_done), .vsync(vsync),
        .push(wr_en), .issue_done(wr_done), .issue_req(wr_req), .wr_addr(wr_addr)
    );

    rd_burst_seq #(.frame_bytes(frame_bytes)) rd_seq_inst (
        .clk_mif(clk_mif), .rst(rst), .calib_done(calib_done), .vsync(vsync),
        .rd_empty(rd_empty), .pix_read_ready(pix_read_ready), .issue_done(rd_done),
        .issue_req(rd_req), .rd_addr(rd_addr)
    );

    cmd_issuer cmd_issuer_inst (
        .clk_mif(clk_mif), .rst(rst), .cmd_full(cmd_full),
        .rd_req(rd_req), .rd_addr(rd_addr), .wr_req(wr_req), .wr_addr(wr_addr),
        .rd_done(rd_done), .wr_done(wr_done),
        .cmd_en(cmd_en), .cmd_instr(cmd_instr), .cmd_addr(cmd_addr)
    );

endmodule

// ==== testbench/mcb_port_model.sv ====
`timescale 1ns/1ps

module mcb_port_model
    import memif_pkg::*;
(
    input  logic       clk_mif,
    input  logic       rst,
    // Command port
    input  logic       cmd_en,
    input  logic [2:0] cmd_instr,
    input  byte_addr_t cmd_addr,
    output logic       cmd_full,
    // Write FIFO
    input  logic       wr_en,
    input  pix_word_t  wr_data,
    output logic       wr_full,
    // Read FIFO, first word fall through
    input  logic       rd_en,
    output pix_word_t  rd_data,
    output logic       rd_empty
);

    localparam int mem_words  = 64;
    localparam int wr_depth   = 32;
    localparam int cmd_depth  = 8;
    localparam int rd_latency = 4;

    pix_word_t  mem [mem_words];
    pix_word_t  wr_fifo [$];
    pix_word_t  rd_fifo [$];
    logic [2:0] cmd_instr_q [$];
    byte_addr_t cmd_addr_q [$];
    int         rd_wait;
    int         stall_left;

    // Word i of the memory holds i until a write burst lands on it
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = pix_word_t'(i);
        end
        cmd_full   = 1'b0;
        wr_full    = 1'b0;
        rd_empty   = 1'b1;
        rd_data    = '0;
        rd_wait    = 0;
        stall_left = 0;
    end

    always @(posedge clk_mif) begin
        int base;
        if (rst) begin
            wr_fifo.delete();
            rd_fifo.delete();
            cmd_instr_q.delete();
            cmd_addr_q.delete();
            rd_wait    = 0;
            stall_left = 0;
            cmd_full   <= 1'b0;
            wr_full    <= 1'b0;
            rd_empty   <= 1'b1;
            rd_data    <= '0;
        end else begin
            if (wr_en) begin
                wr_fifo.push_back(wr_data);
            end
            if (rd_en && rd_fifo.size() > 0) begin
                void'(rd_fifo.pop_front());
            end
            if (cmd_en) begin
                cmd_instr_q.push_back(cmd_instr);
                cmd_addr_q.push_back(cmd_addr);
            end

            ////////////////////////////////////////////////////////////////////
            // Commands run strictly in order, head first
            ////////////////////////////////////////////////////////////////////
            if (cmd_instr_q.size() > 0) begin
                base = cmd_addr_q[0] / word_bytes;
                if (cmd_instr_q[0] == cmd_read) begin
                    // Whole burst appears after the read latency
                    if (rd_wait == rd_latency) begin
                        for (int i = 0; i < burst_len; i++) begin
                            rd_fifo.push_back(mem[(base + i) % mem_words]);
                        end
                        rd_wait = 0;
                        void'(cmd_instr_q.pop_front());
                        void'(cmd_addr_q.pop_front());
                    end else begin
                        rd_wait++;
                    end
                end else if (wr_fifo.size() >= burst_len) begin
                    for (int i = 0; i < burst_len; i++) begin
                        mem[(base + i) % mem_words] = wr_fifo.pop_front();
                    end
                    void'(cmd_instr_q.pop_front());
                    void'(cmd_addr_q.pop_front());
                end
            end

            // Random write stalls of 1 to 3 cycles
            if (stall_left > 0) begin
                stall_left--;
            end else if ($urandom_range(7) == 0) begin
                stall_left = $urandom_range(3, 1);
            end
            // Real fullness keeps margin for the registered push
            wr_full  <= (stall_left > 0) || (wr_fifo.size() >= wr_depth - 2);
            cmd_full <= ($urandom_range(3) == 0) || (cmd_instr_q.size() >= cmd_depth - 2);
            rd_empty <= (rd_fifo.size() == 0);
            if (rd_fifo.size() > 0) begin
                rd_data <= rd_fifo[0];
            end
        end
    end

endmodule

// ==== testbench/memif_tb.sv ====
`timescale 1ns/1ps

module memif_tb
    import memif_pkg::*;
;

    localparam int frame_bytes_tb = 1024;
    localparam int frame_bursts   = frame_bytes_tb / burst_bytes;
    localparam int frame_words    = frame_bytes_tb / word_bytes;
    localparam int frame_timeout  = 5000;
    localparam int quiet_cycles   = 32;

    logic       clk_mif;
    logic       rst;
    logic       calib_done;
    logic       vsync;
    pix_word_t  pix_write;
    logic       pix_write_valid;
    logic       pix_write_ready;
    pix_word_t  pix_read;
    logic       pix_read_valid;
    logic       pix_read_ready;
    logic       cmd_en;
    logic [2:0] cmd_instr;
    byte_addr_t cmd_addr;
    logic       cmd_full;
    logic       wr_en;
    pix_word_t  wr_data;
    logic       wr_full;
    logic       rd_en;
    pix_word_t  rd_data;
    logic       rd_empty;

    // Frame bookkeeping
    logic      armed;
    logic      frame_start;
    int        frame_no;
    int        rd_cmds;
    int        wr_cmds;
    int        words_in;
    int        words_pushed;
    int        words_out;
    int        cycle_count;
    logic      last_fire;
    pix_word_t last_pix;
    pix_word_t expected_rd;
    // Results
    int        error_count;
    int        tests_run;
    int        tests_failed;
    bit        timed_out;

    memif #(.frame_bytes(frame_bytes_tb)) memif_inst (
        .clk_mif(clk_mif), .rst(rst), .calib_done(calib_done), .vsync(vsync),
        .pix_write(pix_write), .pix_write_valid(pix_write_valid),
        .pix_write_ready(pix_write_ready), .pix_read(pix_read),
        .pix_read_valid(pix_read_valid), .pix_read_ready(pix_read_ready),
        .cmd_en(cmd_en), .cmd_instr(cmd_instr), .cmd_addr(cmd_addr), .cmd_full(cmd_full),
        .wr_en(wr_en), .wr_data(wr_data), .wr_full(wr_full),
        .rd_en(rd_en), .rd_data(rd_data), .rd_empty(rd_empty)
    );

    mcb_port_model port_model_inst (
        .clk_mif(clk_mif), .rst(rst),
        .cmd_en(cmd_en), .cmd_instr(cmd_instr), .cmd_addr(cmd_addr), .cmd_full(cmd_full),
        .wr_en(wr_en), .wr_data(wr_data), .wr_full(wr_full),
        .rd_en(rd_en), .rd_data(rd_data), .rd_empty(rd_empty)
    );

    initial begin
        clk_mif = 1'b0;
        forever #5 clk_mif = ~clk_mif;
    end

    // Frame 1 sees the preset memory, later frames the previous frame's pixels
    function automatic pix_word_t expected_pixel(input int frame, input int index);
        if (frame <= 1) begin
            return pix_word_t'(index);
        end
        return pix_word_t'((frame - 1) * 1000 + index);
    endfunction

    assign expected_rd = expected_pixel(frame_no, words_out);

    task automatic note_error(input string msg);
        error_count++;
        $display("%0t: %s", $time, msg);
    endtask

    task automatic note_mismatch(input string name, input pix_word_t got, input pix_word_t exp);
        error_count++;
        $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic report_test(input string name, input int errors_before);
        int new_errors;
        new_errors = error_count - errors_before;
        tests_run++;
        if (new_errors != 0) begin
            tests_failed++;
        end
        $display("%s: %s (%0d errors)", name, (new_errors == 0) ? "pass" : "fail", new_errors);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Pixel source, sink and counters
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk_mif) begin
        int next_in;
        if (rst || frame_start) begin
            pix_write_valid <= 1'b0;
            words_in        <= 0;
        end else if (armed) begin
            next_in = words_in + ((pix_write_valid && pix_write_ready) ? 1 : 0);
            words_in        <= next_in;
            pix_write_valid <= (next_in < frame_words);
            pix_write       <= pix_word_t'(frame_no * 1000 + next_in);
        end
    end

    // Sink takes pixels at random, also while the DUT should stay idle
    always @(posedge clk_mif) begin
        pix_read_ready <= !rst && ($urandom_range(3) != 0);
    end

    always @(posedge clk_mif) begin
        cycle_count <= cycle_count + 1;
        last_fire   <= pix_write_valid && pix_write_ready;
        last_pix    <= pix_write;
        if (rst || frame_start) begin
            rd_cmds      <= 0;
            wr_cmds      <= 0;
            words_pushed <= 0;
            words_out    <= 0;
        end else begin
            if (cmd_en && cmd_instr == cmd_read) begin
                rd_cmds <= rd_cmds + 1;
            end
            if (cmd_en && cmd_instr == cmd_write) begin
                wr_cmds <= wr_cmds + 1;
            end
            // Words that actually reached the controller write FIFO
            if (wr_en) begin
                words_pushed <= words_pushed + 1;
            end
            if (pix_read_valid && pix_read_ready) begin
                words_out <= words_out + 1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    reset_quiet: assert property (@(posedge clk_mif)
        (rst && cycle_count > 0) |-> !(cmd_en || wr_en || rd_en || pix_read_valid))
        else note_error("strobe or pix_read_valid high during reset");

    // Nothing moves before a vsync with calib_done
    idle_quiet: assert property (@(posedge clk_mif) disable iff (rst)
        !armed |-> !(cmd_en || wr_en || rd_en || pix_read_valid))
        else note_error("activity before calib_done and vsync");

    rd_cmd_addr: assert property (@(posedge clk_mif) disable iff (rst)
        (cmd_en && cmd_instr == cmd_read) |-> cmd_addr == byte_addr_t'(rd_cmds * burst_bytes))
        else note_mismatch("cmd_addr", $sampled(cmd_addr), $sampled(rd_cmds) * burst_bytes);

    wr_cmd_addr: assert property (@(posedge clk_mif) disable iff (rst)
        (cmd_en && cmd_instr == cmd_write) |-> cmd_addr == byte_addr_t'(wr_cmds * burst_bytes))
        else note_mismatch("cmd_addr", $sampled(cmd_addr), $sampled(wr_cmds) * burst_bytes);

    cmd_instr_known: assert property (@(posedge clk_mif) disable iff (rst)
        cmd_en |-> (cmd_instr == cmd_read || cmd_instr == cmd_write))
        else note_mismatch("cmd_instr", $sampled(cmd_instr), cmd_read);

    cmd_spacing: assert property (@(posedge clk_mif) disable iff (rst)
        cmd_en |=> !cmd_en)
        else note_error("cmd_en high on two consecutive cycles");

    cmd_after_full: assert property (@(posedge clk_mif) disable iff (rst)
        cmd_en |-> !$past(cmd_full))
        else note_error("command issued right after cmd_full was high");

    // At most one frame of bursts per direction between vsyncs
    cmd_per_frame: assert property (@(posedge clk_mif) disable iff (rst)
        cmd_en |-> ((cmd_instr == cmd_read) ? (rd_cmds < frame_bursts)
                                            : (wr_cmds < frame_bursts)))
        else note_error("command issued after the last burst of the frame");

    wr_order: assert property (@(posedge clk_mif) disable iff (rst)
        (cmd_en && cmd_instr == cmd_write) |-> cmd_addr < byte_addr_t'(rd_cmds * burst_bytes))
        else note_error("write command address not behind the read address");

    rd_data_order: assert property (@(posedge clk_mif) disable iff (rst)
        (pix_read_valid && pix_read_ready) |-> pix_read == expected_rd)
        else note_mismatch("pix_read", $sampled(pix_read), $sampled(expected_rd));

    wr_en_follow: assert property (@(posedge clk_mif) disable iff (rst)
        wr_en == last_fire)
        else note_mismatch("wr_en", $sampled(wr_en), $sampled(last_fire));

    wr_data_follow: assert property (@(posedge clk_mif) disable iff (rst)
        wr_en |-> wr_data == last_pix)
        else note_mismatch("wr_data", $sampled(wr_data), $sampled(last_pix));

    write_ready: assert property (@(posedge clk_mif) disable iff (rst)
        pix_write_ready == !wr_full)
        else note_mismatch("pix_write_ready", $sampled(pix_write_ready), !$sampled(wr_full));

    read_valid: assert property (@(posedge clk_mif) disable iff (rst)
        pix_read_valid == !rd_empty)
        else note_mismatch("pix_read_valid", $sampled(pix_read_valid), !$sampled(rd_empty));

    read_pop: assert property (@(posedge clk_mif) disable iff (rst)
        rd_en == (pix_read_valid && pix_read_ready))
        else note_mismatch("rd_en", $sampled(rd_en), $sampled(pix_read_valid && pix_read_ready));

    //////////////////////////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////////////////////////

    // One vsync, then wait for every burst and pixel of the frame
    task automatic run_frame(input int frame);
        int errors_before;
        int waited;
        bit done;
        errors_before = error_count;
        @(posedge clk_mif);
        frame_no    <= frame;
        frame_start <= 1'b1;
        vsync       <= 1'b1;
        armed       <= 1'b1;
        @(posedge clk_mif);
        frame_start <= 1'b0;
        vsync       <= 1'b0;
        done   = 1'b0;
        waited = 0;
        while (!done && waited < frame_timeout) begin
            @(posedge clk_mif);
            waited++;
            done = (rd_cmds == frame_bursts) && (wr_cmds == frame_bursts) &&
                   (words_out == frame_words) && (words_in == frame_words);
        end
        if (!done) begin
            timed_out = 1'b1;
            $display("timeout: frame %0d did not complete within %0d cycles",
                     frame, frame_timeout);
            return;
        end
        report_test($sformatf("frame %0d data path", frame), errors_before);
        errors_before = error_count;
        // Quiet window after the last burst
        repeat (quiet_cycles) @(posedge clk_mif);
        assert (words_pushed == frame_words)
            else note_mismatch("wr_en pushes", words_pushed, frame_words);
        assert (words_out == frame_words)
            else note_mismatch("words_out", words_out, frame_words);
        report_test($sformatf("frame %0d end", frame), errors_before);
    endtask

    initial begin
        int errors_before;
        void'($urandom(97982));
        rst             = 1'b1;
        calib_done      = 1'b0;
        vsync           = 1'b0;
        pix_write       = '0;
        pix_write_valid = 1'b0;
        pix_read_ready  = 1'b0;
        armed           = 1'b0;
        frame_start     = 1'b0;
        frame_no        = 0;
        cycle_count     = 0;
        last_fire       = 1'b0;
        last_pix        = '0;
        error_count     = 0;
        tests_run       = 0;
        tests_failed    = 0;
        timed_out       = 1'b0;

        // Reset, then a vsync that must be ignored without calib_done
        errors_before = error_count;
        repeat (8) @(posedge clk_mif);
        rst <= 1'b0;
        repeat (4) @(posedge clk_mif);
        vsync <= 1'b1;
        @(posedge clk_mif);
        vsync <= 1'b0;
        repeat (quiet_cycles) @(posedge clk_mif);
        report_test("reset and idle", errors_before);

        calib_done <= 1'b1;
        run_frame(1);
        if (!timed_out) begin
            run_frame(2);
        end

        $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed,
                 error_count);
        if (timed_out || error_count != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

// ==== list.f ====
design/memif_pkg.sv
design/wr_burst_seq.sv
design/rd_burst_seq.sv
design/cmd_issuer.sv
design/memif.sv
testbench/mcb_port_model.sv
testbench/memif_tb.sv
